/* bench/instruction_pipeline_sva.sv */
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module instruction_pipeline_sva(
	input clk,
	input reset,
	input push,
	input pop,
	input valid,
	input [$clog2(`QUEUE_DEPTH + 1) - 1:0] count);

	int assert_failures = 0; // Failed checks so far

	// Push into a full buffer would overwrite the oldest entry
	no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		count == `QUEUE_DEPTH |-> !push)
		else begin
			$error("Queue pushed with all entries occupied");
			assert_failures++;
		end

	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		!valid |-> !pop)
		else begin
			$error("Queue popped while empty");
			assert_failures++;
		end

	count_in_range: assert property (@(posedge clk) disable iff (reset)
		count <= `QUEUE_DEPTH)
		else begin
			$error("Queue count above depth");
			assert_failures++;
		end
endmodule

// Watches every queue instance
bind instruction_queue instruction_pipeline_sva queue_sva_i(
	.clk(clk),
	.reset(reset),
	.push(push_port.push),
	.pop(pop_port.pop),
	.valid(pop_port.valid),
	.count(count));

/* bench/instruction_pipeline_tb.sv */
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module instruction_pipeline_tb;
	typedef logic [31:0] program_t[$];
	typedef logic [34:0] write_list_t[$]; // {reg, value}

	localparam NUM_TESTS = 5;
	localparam MAX_PROGRAM = 21; // Random test, 20 plus HALT
	localparam WATCHDOG_CYCLES = NUM_TESTS * `THREADS_PER_CORE * MAX_PROGRAM
		* `MUL_LATENCY * `THREADS_PER_CORE + NUM_TESTS * 20 + 500;
	localparam REGION_WORDS = 1 << `THREAD_PC_SHIFT;

	logic clk = 1'b0;
	logic reset;
	pipeline_pkg::scalar_t icache_request_addr;
	logic icache_read_en;
	pipeline_pkg::scalar_t icache_data;
	logic processor_halt;
	logic wb_en;
	pipeline_pkg::thread_idx_t wb_thread_idx;
	pipeline_pkg::register_idx_t wb_reg;
	pipeline_pkg::scalar_t wb_value;

	logic [31:0] mem[256]; // Four 64-word thread regions
	logic [7:0] addr_q; // Address of fetch in flight
	program_t prog[`THREADS_PER_CORE];
	write_list_t expected[`THREADS_PER_CORE];
	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int assert_seen = 0; // Queue assertion failures already counted

	instruction_pipeline dut_i(.*);

	always #2 clk = ~clk; // 4 ns clock

	function automatic logic [31:0] encode(input logic [3:0] op, input int d, input int a,
		input int b, input int imm);
		return {op, 3'(d), 3'(a), 3'(b), 3'b000, 16'(imm)};
	endfunction

	// Runs a thread's program up to the first HALT
	function automatic write_list_t reference_writes(input program_t code);
		logic [31:0] regs[`NUM_REGISTERS];
		write_list_t writes;
		logic [31:0] word;
		logic [31:0] imm;
		logic [31:0] value;
		logic writes_reg;
		foreach (regs[r])
			regs[r] = '0;
		foreach (code[i]) begin
			word = code[i];
			imm = {{16{word[15]}}, word[15:0]};
			writes_reg = 1'b1;
			if (word[31:28] == pipeline_pkg::HALT)
				break;
			case (word[31:28])
				pipeline_pkg::LOADI: value = imm;
				pipeline_pkg::ADD: value = regs[word[24:22]] + regs[word[21:19]];
				pipeline_pkg::ADDI: value = regs[word[24:22]] + imm;
				pipeline_pkg::MUL: value = regs[word[24:22]] * regs[word[21:19]];
				default: writes_reg = 1'b0; // NOP and unknown
			endcase
			if (writes_reg) begin
				regs[word[27:25]] = value;
				writes.push_back({word[27:25], value});
			end
		end
		return writes;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("Mismatch %s: got %h expected %h", name, got, want);
			error_count++;
		end
	endtask

	// Memory answers one cycle after the request
	always @(negedge clk) begin
		icache_data <= mem[addr_q];
		addr_q <= icache_request_addr[7:0];
		if (icache_read_en === 1'b1) begin
			if (icache_request_addr / REGION_WORDS >= `THREADS_PER_CORE) begin
				$display("Fetch address %h lies outside every thread region", icache_request_addr);
				error_count++;
			end else if (icache_request_addr % REGION_WORDS
				>= prog[icache_request_addr / REGION_WORDS].size() + `QUEUE_DEPTH) begin
				// Overshoot past HALT is bounded by the queue
				$display("Fetch address %h runs past its thread's program", icache_request_addr);
				error_count++;
			end
		end
	end

	// Writeback checker
	always @(negedge clk) begin
		if (wb_en === 1'b1) begin
			if (expected[wb_thread_idx].size() == 0) begin
				$display("Thread %0d wrote back with no write expected", wb_thread_idx);
				error_count++;
			end else begin
				check_value("wb_reg", 32'(wb_reg), 32'(expected[wb_thread_idx][0][34:32]));
				check_value("wb_value", wb_value, expected[wb_thread_idx][0][31:0]);
				void'(expected[wb_thread_idx].pop_front());
			end
		end
	end

	task automatic run_test(input string name);
		int errors_before;
		int assert_count;
		errors_before = error_count;
		for (int a = 0; a < 256; a++)
			mem[a] = {4'h0, 28'(a * 32'h0001_0101)}; // NOP, address in fields
		for (int t = 0; t < `THREADS_PER_CORE; t++) begin
			for (int i = 0; i < prog[t].size(); i++)
				mem[(t << `THREAD_PC_SHIFT) + i] = prog[t][i];
			expected[t] = reference_writes(prog[t]);
		end
		reset = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (processor_halt !== 1'b0) begin
			$display("processor_halt is high right after reset");
			error_count++;
		end
		while (processor_halt !== 1'b1)
			@(negedge clk);
		for (int t = 0; t < `THREADS_PER_CORE; t++)
			if (expected[t].size() != 0) begin
				$display("Thread %0d halted with %0d writebacks missing", t, expected[t].size());
				error_count++;
			end
		repeat (`QUEUE_DEPTH + 2) @(negedge clk); // Discarded entries drain, stray writes show
		assert_count = dut_i.instruction_queue_i.queue_sva_i.assert_failures;
		if (assert_count != assert_seen) begin
			$display("Queue assertions failed %0d times", assert_count - assert_seen);
			error_count += assert_count - assert_seen;
			assert_seen = assert_count;
		end
		test_count++;
		if (error_count == errors_before)
			$display("Test %s: ok", name);
		else begin
			$display("Test %s: failed with %0d errors", name, error_count - errors_before);
			failed_tests++;
		end
	endtask

	initial begin
		void'($urandom(10585));
		reset = 1'b1;
		icache_data = '0;
		addr_q = '0;

		// Thread 0 alone
		for (int t = 0; t < `THREADS_PER_CORE; t++)
			prog[t] = {encode(pipeline_pkg::HALT, 0, 0, 0, 0)};
		prog[0] = {encode(pipeline_pkg::LOADI, 1, 0, 0, 5),
			encode(pipeline_pkg::ADDI, 2, 1, 0, -3),
			encode(pipeline_pkg::ADD, 3, 1, 2, 0),
			encode(pipeline_pkg::HALT, 0, 0, 0, 0)};
		run_test("single_thread");

		// Different straight-line code per thread
		for (int t = 0; t < `THREADS_PER_CORE; t++) begin
			prog[t] = {};
			prog[t].push_back(encode(pipeline_pkg::LOADI, 1, 0, 0, 100 * t - 7));
			for (int i = 0; i <= t + 2; i++)
				prog[t].push_back(encode(pipeline_pkg::ADDI, (i + 2) % 8, (i + 1) % 8, 0, i * t + 1));
			prog[t].push_back(encode(pipeline_pkg::ADD, 7, 1, 2, 0));
			prog[t].push_back(encode(pipeline_pkg::HALT, 0, 0, 0, 0));
		end
		run_test("four_threads");

		// Multiplies stall execute and fill the queue
		for (int t = 0; t < `THREADS_PER_CORE; t++) begin
			prog[t] = {encode(pipeline_pkg::LOADI, 1, 0, 0, t + 2),
				encode(pipeline_pkg::LOADI, 2, 0, 0, -3)};
			for (int i = 0; i < 12; i++)
				prog[t].push_back(encode(pipeline_pkg::MUL, (i % 5) + 3, (i % 3) + 1, 2, 0));
			prog[t].push_back(encode(pipeline_pkg::HALT, 0, 0, 0, 0));
		end
		run_test("back_pressure");

		// ALU work past HALT must vanish
		for (int t = 0; t < `THREADS_PER_CORE; t++) begin
			prog[t] = {};
			for (int i = 0; i < t * 3; i++)
				prog[t].push_back(encode(pipeline_pkg::ADDI, 1, 1, 0, t + 1));
			prog[t].push_back(encode(pipeline_pkg::HALT, 0, 0, 0, 0));
			for (int i = 0; i < 6; i++)
				prog[t].push_back(encode(pipeline_pkg::LOADI, i, 0, 0, 16'hdead));
		end
		run_test("halt_semantics");

		// Random codes, unknown ones act as NOP
		for (int t = 0; t < `THREADS_PER_CORE; t++) begin
			prog[t] = {};
			for (int i = 0; i < MAX_PROGRAM - 1; i++)
				prog[t].push_back(encode(4'($urandom_range(15, 0)), $urandom_range(7, 0),
					$urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(16'hffff, 0)));
			prog[t].push_back(encode(pipeline_pkg::HALT, 0, 0, 0, 0));
		end
		run_test("random_programs");

		$display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Bound on total run time
	initial begin
		#(WATCHDOG_CYCLES * 4);
		$display("Watchdog expired before all tests finished");
		$display("RESULT: FAIL");
		$finish;
	end
endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module execute_stage(
	input clk,
	input reset,
	queue_pop_if.execute pop_port,
	output logic [`THREADS_PER_CORE - 1:0] thread_enable,
	output logic wb_en,
	output pipeline_pkg::thread_idx_t wb_thread_idx,
	output pipeline_pkg::register_idx_t wb_reg,
	output pipeline_pkg::scalar_t wb_value);

	localparam MUL_COUNT_WIDTH = $clog2(`MUL_LATENCY + 1);

	pipeline_pkg::scalar_t registers[`THREADS_PER_CORE][`NUM_REGISTERS]; // Per-thread files
	pipeline_pkg::instruction_t instr;
	pipeline_pkg::scalar_t operand_a;
	pipeline_pkg::scalar_t operand_b;
	pipeline_pkg::scalar_t imm_ext;
	pipeline_pkg::scalar_t alu_result;
	pipeline_pkg::scalar_t mul_product;
	logic issue; // Popped entry of an enabled thread
	logic [MUL_COUNT_WIDTH - 1:0] mul_count; // Cycles left on multiply
	pipeline_pkg::thread_idx_t mul_thread_idx;
	pipeline_pkg::register_idx_t mul_dest;
	pipeline_pkg::scalar_t mul_result;

	// Decode and operand read
	assign instr = pipeline_pkg::instruction_t'(pop_port.instruction);
	assign operand_a = registers[pop_port.thread_idx][instr.src_a];
	assign operand_b = registers[pop_port.thread_idx][instr.src_b];
	assign imm_ext = {{16{instr.imm[15]}}, instr.imm}; // Sign extend

	// Stall only while a multiply is pending
	assign pop_port.pop = pop_port.valid && mul_count == '0;
	assign issue = pop_port.pop && thread_enable[pop_port.thread_idx]; // Else discard

	always_comb begin
		case (instr.op)
			pipeline_pkg::LOADI: alu_result = imm_ext;
			pipeline_pkg::ADD: alu_result = operand_a + operand_b; // Wraps at 32 bits
			default: alu_result = operand_a + imm_ext; // ADDI
		endcase
	end

	assign mul_product = operand_a * operand_b; // Low word kept

	always_ff @(posedge clk) begin
		if (reset) begin
			thread_enable <= '1; // All threads run
			wb_en <= 1'b0;
			mul_count <= '0;
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				for (int r = 0; r < `NUM_REGISTERS; r++)
					registers[t][r] <= '0;
		end else begin
			wb_en <= 1'b0;
			if (mul_count != '0) begin
				mul_count <= mul_count - 1'b1;
				if (mul_count == MUL_COUNT_WIDTH'(1)) begin
					// Last multiply cycle, retire it
					wb_en <= 1'b1;
					wb_thread_idx <= mul_thread_idx;
					wb_reg <= mul_dest;
					wb_value <= mul_result;
					registers[mul_thread_idx][mul_dest] <= mul_result;
				end
			end else if (issue) begin
				case (instr.op)
					pipeline_pkg::LOADI, pipeline_pkg::ADD, pipeline_pkg::ADDI: begin
						wb_en <= 1'b1; // Single cycle
						wb_thread_idx <= pop_port.thread_idx;
						wb_reg <= instr.dest;
						wb_value <= alu_result;
						registers[pop_port.thread_idx][instr.dest] <= alu_result;
					end
					pipeline_pkg::MUL: begin
						mul_count <= MUL_COUNT_WIDTH'(`MUL_LATENCY);
						mul_thread_idx <= pop_port.thread_idx;
						mul_dest <= instr.dest;
						mul_result <= mul_product;
					end
					pipeline_pkg::HALT:
						thread_enable[pop_port.thread_idx] <= 1'b0; // No writeback
					default: ; // NOP and unknown codes
				endcase
			end
		end
	end
endmodule

/* hdl/ifetch_stage.sv */
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module ifetch_stage(
	input clk,
	input reset,
	input [`THREADS_PER_CORE - 1:0] thread_enable,
	output pipeline_pkg::scalar_t icache_request_addr,
	output logic icache_read_en,
	input pipeline_pkg::scalar_t icache_data,
	queue_push_if.fetch push_port);

	pipeline_pkg::scalar_t thread_pc[`THREADS_PER_CORE]; // Next fetch address per thread
	pipeline_pkg::thread_idx_t last_thread; // Last thread served
	pipeline_pkg::thread_idx_t selected_thread;
	pipeline_pkg::thread_idx_t candidate;
	logic thread_found;
	logic fetch_en;
	logic fetch_pending; // Fetch in flight
	pipeline_pkg::thread_idx_t fetch_thread;
	pipeline_pkg::scalar_t fetch_pc;

	// Round robin, first enabled thread after the last one served
	always_comb begin
		selected_thread = last_thread;
		thread_found = 1'b0;
		candidate = last_thread;
		for (int i = 1; i <= `THREADS_PER_CORE; i++) begin
			candidate = pipeline_pkg::thread_idx_t'(last_thread + i); // Wraps
			if (!thread_found && thread_enable[candidate]) begin
				selected_thread = candidate;
				thread_found = 1'b1;
			end
		end
	end

	// Queue keeps a slot for the fetch in flight
	assign fetch_en = thread_found && !push_port.full && !reset;
	assign icache_read_en = fetch_en;
	assign icache_request_addr = thread_pc[selected_thread];

	always_ff @(posedge clk) begin
		if (reset) begin
			last_thread <= pipeline_pkg::thread_idx_t'(`THREADS_PER_CORE - 1); // Thread 0 first
			fetch_pending <= 1'b0;
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				thread_pc[t] <= pipeline_pkg::scalar_t'(t) << `THREAD_PC_SHIFT;
		end else begin
			fetch_pending <= fetch_en;
			if (fetch_en) begin
				last_thread <= selected_thread;
				thread_pc[selected_thread] <= thread_pc[selected_thread] + 1'b1; // Next word
			end
		end
	end

	// Thread and PC follow the request by one cycle
	always_ff @(posedge clk) begin
		if (fetch_en) begin
			fetch_thread <= selected_thread;
			fetch_pc <= thread_pc[selected_thread];
		end
	end

	assign push_port.push = fetch_pending; // Data arrives now
	assign push_port.thread_idx = fetch_thread;
	assign push_port.pc = fetch_pc;
	assign push_port.instruction = icache_data;
endmodule

/* hdl/instruction_pipeline.sv */
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module instruction_pipeline(
	input clk,
	input reset,
	output pipeline_pkg::scalar_t icache_request_addr,
	output logic icache_read_en,
	input pipeline_pkg::scalar_t icache_data, // Valid cycle after read_en
	output logic processor_halt,
	output logic wb_en,
	output pipeline_pkg::thread_idx_t wb_thread_idx,
	output pipeline_pkg::register_idx_t wb_reg,
	output pipeline_pkg::scalar_t wb_value);

	logic [`THREADS_PER_CORE - 1:0] thread_enable; // From execute

	queue_push_if push_if(); // Fetch to queue
	queue_pop_if pop_if(); // Queue to execute

	ifetch_stage ifetch_stage_i(
		.clk(clk),
		.reset(reset),
		.thread_enable(thread_enable),
		.icache_request_addr(icache_request_addr),
		.icache_read_en(icache_read_en),
		.icache_data(icache_data),
		.push_port(push_if.fetch));

	instruction_queue instruction_queue_i(
		.clk(clk),
		.reset(reset),
		.push_port(push_if.queue),
		.pop_port(pop_if.queue));

	execute_stage execute_stage_i(
		.clk(clk),
		.reset(reset),
		.pop_port(pop_if.execute),
		.thread_enable(thread_enable),
		.wb_en(wb_en),
		.wb_thread_idx(wb_thread_idx),
		.wb_reg(wb_reg),
		.wb_value(wb_value));

	assign processor_halt = !(|thread_enable); // Every thread halted
endmodule

/* hdl/instruction_queue.sv */
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module instruction_queue(
	input clk,
	input reset,
	queue_push_if.queue push_port,
	queue_pop_if.queue pop_port);

	localparam PTR_WIDTH = $clog2(`QUEUE_DEPTH);
	localparam COUNT_WIDTH = $clog2(`QUEUE_DEPTH + 1);

	pipeline_pkg::queue_entry_t entries[`QUEUE_DEPTH]; // Circular storage
	logic [PTR_WIDTH - 1:0] rd_ptr; // Oldest entry
	logic [PTR_WIDTH - 1:0] wr_ptr; // Next free slot
	logic [COUNT_WIDTH - 1:0] count; // Occupied slots
	pipeline_pkg::queue_entry_t head;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push_port.push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			if (pop_port.pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_port.push, pop_port.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Entry write, no reset needed
	always_ff @(posedge clk) begin
		if (push_port.push) begin
			entries[wr_ptr].thread_idx <= push_port.thread_idx;
			entries[wr_ptr].pc <= push_port.pc;
			entries[wr_ptr].instruction <= push_port.instruction;
		end
	end

	// Nearly full, one slot stays free for the fetch in flight
	assign push_port.full = count >= COUNT_WIDTH'(`QUEUE_DEPTH - 1);

	// Registered count, so a push shows up a cycle later
	assign pop_port.valid = count != '0;
	assign head = entries[rd_ptr];
	assign pop_port.thread_idx = head.thread_idx;
	assign pop_port.pc = head.pc;
	assign pop_port.instruction = head.instruction;
endmodule

/* hdl/pipeline_defines.svh */
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

// Core configuration
`define THREADS_PER_CORE 4 // Hardware threads, power of two
`define QUEUE_DEPTH 4 // Fetched instruction slots, power of two
`define NUM_REGISTERS 8 // Registers per thread

// Execute timing
`define MUL_LATENCY 3 // Cycles a multiply holds execute

// Thread t starts at word t << THREAD_PC_SHIFT
`define THREAD_PC_SHIFT 6 // 64-word region per thread

`endif

/* hdl/pipeline_pkg.sv */
`include "pipeline_defines.svh"

package pipeline_pkg;
	typedef logic [31:0] scalar_t; // Data word and word address
	typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] thread_idx_t;
	typedef logic [$clog2(`NUM_REGISTERS) - 1:0] register_idx_t;

	typedef enum logic [3:0] {
		NOP = 4'd0,
		LOADI = 4'd1, // dest = imm
		ADD = 4'd2, // dest = a + b
		ADDI = 4'd3, // dest = a + imm
		MUL = 4'd4, // dest = low word of a * b
		HALT = 4'd5 // Disables the issuing thread
	} opcode_t; // Unlisted codes run as NOP

	// Instruction word layout, MSB first
	typedef struct packed {
		opcode_t op; // Bits 31:28
		register_idx_t dest; // Bits 27:25
		register_idx_t src_a; // Bits 24:22
		register_idx_t src_b; // Bits 21:19
		logic [2:0] unused; // Bits 18:16
		logic [15:0] imm; // Signed immediate
	} instruction_t;

	// Queue storage word
	typedef struct packed {
		thread_idx_t thread_idx;
		scalar_t pc;
		scalar_t instruction;
	} queue_entry_t;
endpackage

/* hdl/queue_pop_if.sv */
`timescale 1ns/100ps

// Queue read side to execute stage
interface queue_pop_if;
	logic valid; // Queue not empty
	pipeline_pkg::thread_idx_t thread_idx; // Oldest entry
	pipeline_pkg::scalar_t pc;
	pipeline_pkg::scalar_t instruction;
	logic pop; // Strobe, removes oldest this cycle

	modport queue(
		output valid, thread_idx, pc, instruction,
		input pop);

	modport execute(
		input valid, thread_idx, pc, instruction,
		output pop);
endinterface

/* hdl/queue_push_if.sv */
`timescale 1ns/100ps

// Fetch stage to queue write side
interface queue_push_if;
	logic push; // Strobe, fields valid this cycle
	pipeline_pkg::thread_idx_t thread_idx;
	pipeline_pkg::scalar_t pc;
	pipeline_pkg::scalar_t instruction;
	logic full; // Fewer than two free slots

	modport fetch(
		output push, thread_idx, pc, instruction,
		input full);

	modport queue(
		input push, thread_idx, pc, instruction,
		output full);
endinterface

/* sources.f */
+incdir+hdl
hdl/pipeline_pkg.sv
hdl/queue_push_if.sv
hdl/queue_pop_if.sv
hdl/ifetch_stage.sv
hdl/instruction_queue.sv
hdl/execute_stage.sv
hdl/instruction_pipeline.sv
bench/instruction_pipeline_sva.sv
bench/instruction_pipeline_tb.sv
